// File: src.f
design/chip8_pkg.sv
design/op_decoder.sv
design/op_fifo.sv
design/exec_unit.sv
design/chip8_core.sv
test/chip8_core_assertions.sv
test/tb_chip8_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_chip8_core
FILELIST  ?= src.f

OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := TEST FAILED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/tb_chip8_core.sv
// Testbench for the CHIP-8 register core
// LFSR opcode stream under credit control, checked against a register model
module tb_chip8_core;
    import chip8_pkg::*;

    localparam int OPS_PER_TEST = 40;
    localparam int TOTAL_OPS    = NUM_REGS + 5 * OPS_PER_TEST;
    localparam int CYCLE_LIMIT  = 8 * TOTAL_OPS + 2000;

    // Low nibbles of the flag-setting group 8 ops, and the skip opcodes
    localparam logic [3:0] ARITH_N [8] = '{4'h4, 4'h5, 4'h6, 4'h7, 4'hE, 4'h4, 4'h5, 4'h7};
    localparam logic [3:0] SKIP_T [4]  = '{4'h3, 4'h4, 4'h5, 4'h9};

    logic                clk;
    logic                arst_n;
    logic                instr_valid;
    logic [OPCODE_W-1:0] instr;
    logic                hold;
    logic                instr_credit;
    logic                wb_valid;
    wb_t                 wb;

    logic [15:0]         lfsr;
    int                  src_credits;
    int                  hold_left;
    bit                  hold_mode;
    int                  cycles;
    int                  errors;
    int                  tests_passed;
    int                  tests_failed;
    string               cur_test;
    logic [DATA_W-1:0]   model_regs [NUM_REGS];
    bit                  model_skip;
    wb_t                 exp_q [$];

    chip8_core u_chip8_core (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .hold         (hold),
        .instr_credit (instr_credit),
        .wb_valid     (wb_valid),
        .wb           (wb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Fibonacci LFSR x^16+x^14+x^13+x^11+1, one step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            val  = {val[14:0], fb};
        end
        return val;
    endfunction

    // Random opcode for one test mode, mode 6 mixes modes 2 to 5
    function automatic logic [OPCODE_W-1:0] make_op(input int mode);
        logic [3:0] x;
        logic [3:0] y;
        logic [3:0] t;
        logic [7:0] kk;
        int         m;
        x  = 4'(rand_bits(4));
        y  = 4'(rand_bits(4));
        kk = 8'(rand_bits(8));
        m  = (mode == 6) ? 2 + int'(rand_bits(2)) : mode;
        // Flag ops hit VF as destination now and then
        if (m == 4 && rand_bits(2) == 0) x = 4'hF;
        case (m)
            3: begin
                if (rand_bits(2) == 0) return {4'h6, x, kk};
                return {4'h8, x, y, 2'b00, 2'(rand_bits(2))};
            end
            4: begin
                if (rand_bits(3) == 0) return {4'h6, x, kk};
                return {4'h8, x, y, ARITH_N[3'(rand_bits(3))]};
            end
            5: begin
                t = 4'(rand_bits(3));
                // Unknown opcodes, dropped groups or an undefined 8xyF
                if (t == 4'd2) begin
                    if (rand_bits(1) != 0) return {4'hA + 4'(rand_bits(2)), x, kk};
                    return {4'h8, x, y, 4'hF};
                end
                if (t > 4'd2) return {(rand_bits(1) != 0) ? 4'h6 : 4'h7, x, kk};
                // Bias compares toward equal so both skip outcomes show up
                if (rand_bits(1) != 0) kk = model_regs[x];
                if (rand_bits(1) != 0) y = x;
                t = SKIP_T[2'(rand_bits(2))];
                return (t < 4'h5) ? {t, x, kk} : {t, x, y, 4'h0};
            end
            default: return {(rand_bits(1) != 0) ? 4'h6 : 4'h7, x, kk};
        endcase
    endfunction

    // Reference model, applied in send order
    task automatic model_apply(input logic [OPCODE_W-1:0] op);
        logic [3:0]        x;
        logic [3:0]        y;
        logic [DATA_W-1:0] kk;
        logic [DATA_W-1:0] vx;
        logic [DATA_W-1:0] vy;
        wb_t               rec;
        bit                wr;
        x  = op[11:8];
        y  = op[7:4];
        kk = op[7:0];
        vx = model_regs[x];
        vy = model_regs[y];
        if (model_skip) begin
            // Discarded by the skip before it
            model_skip = 1'b0;
            return;
        end
        wr = (op[15:12] inside {4'h6, 4'h7})
            || (op[15:12] == 4'h8 && op[3:0] inside {[4'h0:4'h7], 4'hE});
        rec.x     = x;
        rec.vx    = vx;
        rec.vf_we = (op[15:12] == 4'h8) && (op[3:0] inside {[4'h4:4'h7], 4'hE});
        rec.vf    = '0;
        case (op[15:12])
            4'h3: model_skip = (vx == kk);
            4'h4: model_skip = (vx != kk);
            4'h5: model_skip = (op[3:0] == 4'h0) && (vx == vy);
            4'h6: rec.vx = kk;
            4'h7: rec.vx = vx + kk;
            4'h8: begin
                case (op[3:0])
                    4'h0: rec.vx = vy;
                    4'h1: rec.vx = vx | vy;
                    4'h2: rec.vx = vx & vy;
                    4'h3: rec.vx = vx ^ vy;
                    // Carry, not-borrow or shifted-out bit lands in VF
                    4'h4: {rec.vf, rec.vx} = {7'd0, {1'b0, vx} + {1'b0, vy}};
                    4'h5: {rec.vf, rec.vx} = {7'd0, vx > vy, vx - vy};
                    4'h6: {rec.vf, rec.vx} = {7'd0, vx[0], vx >> 1};
                    4'h7: {rec.vf, rec.vx} = {7'd0, vy > vx, vy - vx};
                    4'hE: {rec.vf, rec.vx} = {7'd0, vx[7], vx << 1};
                    default: ;
                endcase
            end
            4'h9: model_skip = (op[3:0] == 4'h0) && (vx != vy);
            default: ;
        endcase
        if (wr) begin
            model_regs[x] = rec.vx;
            // VF last, so it wins when x is 15
            if (rec.vf_we) model_regs[FLAG_REG] = rec.vf;
            exp_q.push_back(rec);
        end
    endtask

    task automatic check_wb(input wb_t exp, input wb_t act);
        if (act.x !== exp.x || act.vx !== exp.vx || act.vf_we !== exp.vf_we
                || (exp.vf_we && act.vf !== exp.vf)) begin
            $display("Fail %s: expected V%0d=%h (VF %b/%h), actual V%0d=%h (VF %b/%h)",
                     cur_test, exp.x, exp.vx, exp.vf_we, exp.vf,
                     act.x, act.vx, act.vf_we, act.vf);
            errors++;
        end
    endtask

    // One clock, inputs change 1 unit after the edge
    task automatic step();
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        if (instr_credit) src_credits++;
        if (src_credits > SRC_CREDITS) begin
            $display("%s: decoder returned more credits than the source spent", cur_test);
            errors++;
        end
        if (hold_left > 0) hold_left--;
        else if (hold_mode && rand_bits(3) == 0) hold_left = 4 + int'(rand_bits(4));
        hold = (hold_left > 0);
    endtask

    // Wait for a credit and a random go, then send for one cycle
    task automatic send_op(input logic [OPCODE_W-1:0] op);
        step();
        while (src_credits == 0 || rand_bits(2) == 0) step();
        instr_valid = 1'b1;
        instr       = op;
        src_credits--;
        model_apply(op);
    endtask

    task automatic run_test(input string name, input int mode);
        int                  start_errors;
        int                  wait_cycles;
        logic [OPCODE_W-1:0] op;
        cur_test     = name;
        start_errors = errors;
        hold_mode    = (mode == 6);
        if (mode == 1 && (wb_valid || instr_credit)) begin
            $display("%s: outputs active right after reset", name);
            errors++;
        end
        // Reset test adds to every register once, results show the zero start
        for (int i = 0; i < ((mode == 1) ? NUM_REGS : OPS_PER_TEST); i++) begin
            op = (mode == 1) ? {4'h7, 4'(i), 8'(rand_bits(8))} : make_op(mode);
            send_op(op);
        end
        hold_mode   = 1'b0;
        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < 64) begin
            step();
            wait_cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected writebacks never arrived", name, exp_q.size());
            errors++;
            exp_q.delete();
        end
        // Let trailing skips and no-ops leave the pipe
        repeat (8) step();
        if (src_credits != SRC_CREDITS) begin
            $display("%s: source left with %0d credits once idle", name, src_credits);
            errors++;
        end
        if (errors == start_errors) begin
            $display("test %-14s passed", name);
            tests_passed++;
        end else begin
            $display("test %-14s failed with %0d errors", name, errors - start_errors);
            tests_failed++;
        end
    endtask

    // Writeback monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (arst_n && wb_valid) begin
            if (exp_q.size() == 0) begin
                $display("%s: writeback to V%0d with no write expected", cur_test, wb.x);
                errors++;
            end else begin
                check_wb(exp_q.pop_front(), wb);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the opcode stream stalled", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        lfsr         = 16'd16756;
        arst_n       = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        hold         = 1'b0;
        src_credits  = SRC_CREDITS;
        hold_left    = 0;
        hold_mode    = 1'b0;
        cycles       = 0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        model_skip   = 1'b0;
        cur_test     = "reset";
        foreach (model_regs[i]) model_regs[i] = '0;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        run_test("reset", 1);
        run_test("imm_load_add", 2);
        run_test("logic_move", 3);
        run_test("arith_flags", 4);
        run_test("skip_nop", 5);
        run_test("back_pressure", 6);
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: test/chip8_core_assertions.sv
// Credit and occupancy rules for the decoder and the instruction buffer
// Level is the decoder's credit count or the buffer's entry count
module chip8_core_assertions (
    input logic                           clk,
    input logic                           arst_n,
    input logic [chip8_pkg::CREDIT_W-1:0] level,
    input logic                           give,
    input logic                           out_pulse
);
    import chip8_pkg::*;

    // Never more than the buffer can hold
    a_level_max: assert property (@(posedge clk) disable iff (!arst_n)
        level <= CREDIT_W'(FIFO_DEPTH))
        else $error("level %0d above buffer depth", level);

    // Refund needs a spent credit, push needs a free entry
    a_give_room: assert property (@(posedge clk) disable iff (!arst_n)
        give |-> level < CREDIT_W'(FIFO_DEPTH))
        else $error("level raised while already at buffer depth");

    // Credit pulses quiet in the first cycle out of reset
    a_reset_quiet: assert property (@(posedge clk) $rose(arst_n) |-> !out_pulse)
        else $error("credit pulse in first cycle after reset");

endmodule

bind op_decoder chip8_core_assertions u_dec_assertions (
    .clk       (clk),
    .arst_n    (arst_n),
    .level     (credit),
    .give      (pop_credit),
    .out_pulse (instr_credit)
);

bind op_fifo chip8_core_assertions u_fifo_assertions (
    .clk       (clk),
    .arst_n    (arst_n),
    .level     (count),
    .give      (push),
    .out_pulse (pop_credit)
);

// File: design/chip8_core.sv
// CHIP-8 register execution core
// Decoder, instruction buffer and execute unit chained with credit flow control
module chip8_core (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           instr_valid,
    input  logic [chip8_pkg::OPCODE_W-1:0] instr,
    input  logic                           hold,
    output logic                           instr_credit,
    output logic                           wb_valid,
    output chip8_pkg::wb_t                 wb
);
    import chip8_pkg::*;

    // Decoder to buffer
    logic    push;
    dec_op_t push_op;
    logic    pop_credit;

    // Buffer to execute unit
    logic    not_empty;
    dec_op_t head_op;
    logic    pop;

    op_decoder u_op_decoder (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .pop_credit   (pop_credit),
        .instr_credit (instr_credit),
        .push         (push),
        .push_op      (push_op)
    );

    op_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_op_fifo (
        .clk        (clk),
        .arst_n     (arst_n),
        .push       (push),
        .push_op    (push_op),
        .pop        (pop),
        .not_empty  (not_empty),
        .head_op    (head_op),
        .pop_credit (pop_credit)
    );

    exec_unit u_exec_unit (
        .clk       (clk),
        .arst_n    (arst_n),
        .hold      (hold),
        .not_empty (not_empty),
        .head_op   (head_op),
        .pop       (pop),
        .wb_valid  (wb_valid),
        .wb        (wb)
    );

endmodule

// File: design/exec_unit.sv
// CHIP-8 execute unit
// Register file, ALU with VF rules, skip handling and writeback output
module exec_unit (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               hold,
    input  logic               not_empty,
    input  chip8_pkg::dec_op_t head_op,
    output logic               pop,
    output logic               wb_valid,
    output chip8_pkg::wb_t     wb
);
    import chip8_pkg::*;

    logic [DATA_W-1:0] regs [NUM_REGS];
    logic              skip_pending;
    logic [DATA_W-1:0] vx;
    logic [DATA_W-1:0] vy;
    logic [DATA_W:0]   sum;
    logic              wr_en;
    logic              vf_we;
    logic              skip_cond;
    logic              do_write;
    logic [DATA_W-1:0] vx_new;
    logic [DATA_W-1:0] vf_new;

    // Take the head whenever there is one and we are not held
    assign pop = not_empty && !hold;

    // Operand read
    assign vx  = regs[head_op.x];
    assign vy  = regs[head_op.y];
    assign sum = {1'b0, vx} + {1'b0, vy};

    // ALU, result and flag per class, all mod 256
    always_comb begin
        wr_en     = 1'b1;
        vf_we     = 1'b0;
        skip_cond = 1'b0;
        vx_new    = vx;
        vf_new    = '0;
        case (head_op.cls)
            OP_LD_IMM:  vx_new = head_op.kk;
            OP_ADD_IMM: vx_new = vx + head_op.kk;
            OP_MOV:     vx_new = vy;
            OP_OR:      vx_new = vx | vy;
            OP_AND:     vx_new = vx & vy;
            OP_XOR:     vx_new = vx ^ vy;
            OP_ADD_C: begin
                vx_new = sum[DATA_W-1:0];
                vf_we  = 1'b1;
                vf_new = DATA_W'(sum[DATA_W]);
            end
            OP_SUB: begin
                vx_new = vx - vy;
                vf_we  = 1'b1;
                vf_new = DATA_W'(vx > vy);    // Not-borrow
            end
            OP_SUBN: begin
                vx_new = vy - vx;
                vf_we  = 1'b1;
                vf_new = DATA_W'(vy > vx);
            end
            OP_SHR: begin
                vx_new = vx >> 1;
                vf_we  = 1'b1;
                vf_new = DATA_W'(vx[0]);
            end
            OP_SHL: begin
                vx_new = vx << 1;
                vf_we  = 1'b1;
                vf_new = DATA_W'(vx[DATA_W-1]);
            end
            // Skips write nothing, they only arm the pending flag
            OP_SE_IMM: begin
                wr_en     = 1'b0;
                skip_cond = (vx == head_op.kk);
            end
            OP_SNE_IMM: begin
                wr_en     = 1'b0;
                skip_cond = (vx != head_op.kk);
            end
            OP_SE_REG: begin
                wr_en     = 1'b0;
                skip_cond = (vx == vy);
            end
            OP_SNE_REG: begin
                wr_en     = 1'b0;
                skip_cond = (vx != vy);
            end
            default: wr_en = 1'b0;    // No-op
        endcase
    end

    // Popped op that is not discarded by a pending skip
    assign do_write = pop && wr_en && !skip_pending;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            skip_pending <= 1'b0;
            wb_valid     <= 1'b0;
        end else begin
            wb_valid <= do_write;
            if (pop) begin
                // Discarded op just clears the flag
                skip_pending <= skip_pending ? 1'b0 : skip_cond;
            end
            if (do_write) begin
                regs[head_op.x] <= vx_new;
                // Later assignment, so VF wins when x is 15
                if (vf_we) regs[FLAG_REG] <= vf_new;
            end
        end
    end

    // Writeback record mirrors what went into the register file
    always_ff @(posedge clk) begin
        if (do_write) begin
            wb.x     <= head_op.x;
            wb.vx    <= vx_new;
            wb.vf_we <= vf_we;
            wb.vf    <= vf_new;
        end
    end

endmodule

// File: design/op_fifo.sv
// Instruction buffer between decoder and execute unit
// Circular FIFO of decoded ops, space guaranteed by the decoder's credits
module op_fifo #(
    parameter int DEPTH = chip8_pkg::FIFO_DEPTH
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               push,
    input  chip8_pkg::dec_op_t push_op,
    input  logic               pop,
    output logic               not_empty,
    output chip8_pkg::dec_op_t head_op,
    output logic               pop_credit
);
    import chip8_pkg::*;

    // DEPTH is a power of two, pointers wrap on their own
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    dec_op_t          mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Storage, no full check needed
    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= push_op;
    end

    // Pointers and occupancy
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // Head comes straight from the registered storage
    // so a push into an empty buffer shows up one cycle later
    assign not_empty = (count != '0);
    assign head_op   = mem[rd_ptr];

    // Every freed entry returns one credit to the decoder
    assign pop_credit = pop;

endmodule

// File: design/op_decoder.sv
// CHIP-8 opcode decoder
// Holds one raw opcode, classifies it and pushes the record under credit control
module op_decoder (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           instr_valid,
    input  logic [chip8_pkg::OPCODE_W-1:0] instr,
    input  logic                           pop_credit,
    output logic                           instr_credit,
    output logic                           push,
    output chip8_pkg::dec_op_t             push_op
);
    import chip8_pkg::*;

    logic                slot_valid;
    logic [OPCODE_W-1:0] slot_instr;
    logic [CREDIT_W-1:0] credit;
    op_class_e           cls;

    // Classification on top nibble
    // Low nibble selects the ALU op in group 8 and qualifies 5xy0 / 9xy0
    always_comb begin
        cls = OP_NOP;
        case (slot_instr[15:12])
            4'h3: cls = OP_SE_IMM;
            4'h4: cls = OP_SNE_IMM;
            4'h5: if (slot_instr[3:0] == 4'h0) cls = OP_SE_REG;
            4'h6: cls = OP_LD_IMM;
            4'h7: cls = OP_ADD_IMM;
            4'h8: begin
                case (slot_instr[3:0])
                    4'h0:    cls = OP_MOV;
                    4'h1:    cls = OP_OR;
                    4'h2:    cls = OP_AND;
                    4'h3:    cls = OP_XOR;
                    4'h4:    cls = OP_ADD_C;
                    4'h5:    cls = OP_SUB;
                    4'h6:    cls = OP_SHR;
                    4'h7:    cls = OP_SUBN;
                    4'hE:    cls = OP_SHL;
                    default: cls = OP_NOP;
                endcase
            end
            4'h9: if (slot_instr[3:0] == 4'h0) cls = OP_SNE_REG;
            default: cls = OP_NOP;
        endcase
    end

    // Field extraction, x and y nibbles plus the kk byte
    assign push_op.cls = cls;
    assign push_op.x   = slot_instr[11:8];
    assign push_op.y   = slot_instr[7:4];
    assign push_op.kk  = slot_instr[7:0];

    // Move to the buffer only while it has a free entry
    assign push = slot_valid && (credit != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_valid   <= 1'b0;
            credit       <= CREDIT_W'(FIFO_DEPTH);
            instr_credit <= 1'b0;
        end else begin
            if (push) slot_valid <= 1'b0;
            if (instr_valid) slot_valid <= 1'b1;
            // Spend on push, refund on every buffer pop
            credit       <= credit - CREDIT_W'(push) + CREDIT_W'(pop_credit);
            // Slot freed, hand the source its credit back
            instr_credit <= push;
        end
    end

    // Raw opcode capture
    always_ff @(posedge clk) begin
        if (instr_valid) slot_instr <= instr;
    end

endmodule

// File: design/chip8_pkg.sv
// CHIP-8 register core shared definitions
// Widths, operation classes, credit depth and the records passed between stages
package chip8_pkg;

    // Raw instruction and register widths
    localparam int OPCODE_W  = 16;
    localparam int DATA_W    = 8;
    localparam int REG_IDX_W = 4;
    localparam int NUM_REGS  = 16;

    // VF carries carry, not-borrow and shifted-out bit
    localparam int FLAG_REG  = 15;

    // Instruction buffer entries, also the decoder's starting credits
    localparam int FIFO_DEPTH = 4;

    // Decoder has a single input slot
    localparam int SRC_CREDITS = 1;

    // Must hold FIFO_DEPTH
    localparam int CREDIT_W = 3;

    // Decoded operation classes
    typedef enum logic [3:0] {
        OP_NOP      = 4'd0,   // Unknown or dropped opcode
        OP_LD_IMM   = 4'd1,   // 6xkk
        OP_ADD_IMM  = 4'd2,   // 7xkk, VF untouched
        OP_MOV      = 4'd3,   // 8xy0
        OP_OR       = 4'd4,   // 8xy1
        OP_AND      = 4'd5,   // 8xy2
        OP_XOR      = 4'd6,   // 8xy3
        OP_ADD_C    = 4'd7,   // 8xy4
        OP_SUB      = 4'd8,   // 8xy5
        OP_SUBN     = 4'd9,   // 8xy7
        OP_SHR      = 4'd10,  // 8xy6
        OP_SHL      = 4'd11,  // 8xyE
        OP_SE_IMM   = 4'd12,  // 3xkk
        OP_SNE_IMM  = 4'd13,  // 4xkk
        OP_SE_REG   = 4'd14,  // 5xy0
        OP_SNE_REG  = 4'd15   // 9xy0
    } op_class_e;

    // One decoded instruction as it travels through the buffer
    typedef struct packed {
        op_class_e            cls;
        logic [REG_IDX_W-1:0] x;
        logic [REG_IDX_W-1:0] y;
        logic [DATA_W-1:0]    kk;
    } dec_op_t;

    // One register writeback
    // VF fields only meaningful when vf_we is set
    typedef struct packed {
        logic [REG_IDX_W-1:0] x;
        logic [DATA_W-1:0]    vx;
        logic                 vf_we;
        logic [DATA_W-1:0]    vf;
    } wb_t;

endpackage
